//--- simt_alu.f
+incdir+sim
design/simt_alu_pkg.sv
design/pipe_register.sv
design/int_multiplier.sv
design/alu_unit.sv
sim/alu_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f simt_alu.f --top-module alu_unit_tb \
    --Mdir obj_dir -o alu_unit_tb_sim

./obj_dir/alu_unit_tb_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

//--- sim/alu_vectors.svh
// Columns are class, op, use_pc, use_imm, pc, next_pc, imm, tid, rs1, rs2,
// expected data (thread 3 down to thread 0), check data, taken and dest
typedef struct packed {
    op_class_e       cls;
    logic [3:0]      op;
    logic            use_pc;
    logic            use_imm;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] imm;
    logic [1:0]      tid;
    thread_data_t    rs1;
    thread_data_t    rs2;
    thread_data_t    exp_data;
    logic            chk_data;
    logic            taken;
    logic [XLEN-1:0] dest;
} vec_t;

localparam int NUM_VECS = 24;

// Operand sets with thread 3 first
localparam thread_data_t OP_A = {32'h12345678, 32'h80000000, 32'hFFFFFFF0, 32'h00000005};
localparam thread_data_t OP_B = {32'hFFFFFFFF, 32'h00000001, 32'h00000004, 32'h00000003};
localparam thread_data_t BR_1 = {32'h00000007, 32'hFFFFFFFE, 32'h00000007, 32'h00000007};
localparam thread_data_t BR_2 = {32'h00000007, 32'h00000002, 32'h00000007, 32'h00000007};
localparam thread_data_t MUL_1 = {32'h00000003, 32'h7FFFFFFF, 32'h80000000, 32'hFFFFFFFF};
localparam thread_data_t MUL_2 = {32'h00000005, 32'hFFFFFFFF, 32'h80000000, 32'hFFFFFFFF};
localparam thread_data_t ZERO = '0;

vec_t vectors [NUM_VECS] = '{
    '{OPC_ALU, ADD, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, OP_A, OP_B,
        {32'h12345677, 32'h80000001, 32'hFFFFFFF4, 32'h00000008}, 1'b1, 1'b0, 32'h0},
    '{OPC_MUL, 4'(MUL), 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, MUL_1, MUL_2,
        {32'h0000000F, 32'h80000001, 32'h00000000, 32'h00000001}, 1'b1, 1'b0, 32'h0},
    '{OPC_ALU, SUB, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, OP_A, OP_B,
        {32'h12345679, 32'h7FFFFFFF, 32'hFFFFFFEC, 32'h00000002}, 1'b1, 1'b0, 32'h0},
    '{OPC_ALU, AND, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, OP_A, OP_B,
        {32'h12345678, 32'h00000000, 32'h00000000, 32'h00000001}, 1'b1, 1'b0, 32'h0},
    '{OPC_MUL, 4'(MULH), 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, MUL_1, MUL_2,
        {32'h00000000, 32'hFFFFFFFF, 32'h40000000, 32'h00000000}, 1'b1, 1'b0, 32'h0},
    '{OPC_ALU, OR, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, OP_A, OP_B,
        {32'hFFFFFFFF, 32'h80000001, 32'hFFFFFFF4, 32'h00000007}, 1'b1, 1'b0, 32'h0},
    '{OPC_ALU, XOR, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, OP_A, OP_B,
        {32'hEDCBA987, 32'h80000001, 32'hFFFFFFF4, 32'h00000006}, 1'b1, 1'b0, 32'h0},
    '{OPC_ALU, SLL, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, OP_A, OP_B,
        {32'h00000000, 32'h00000000, 32'hFFFFFF00, 32'h00000028}, 1'b1, 1'b0, 32'h0},
    '{OPC_MUL, 4'(MULHSU), 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, MUL_1, MUL_2,
        {32'h00000000, 32'h7FFFFFFE, 32'hC0000000, 32'hFFFFFFFF}, 1'b1, 1'b0, 32'h0},
    '{OPC_ALU, SRL, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, OP_A, OP_B,
        {32'h00000000, 32'h40000000, 32'h0FFFFFFF, 32'h00000000}, 1'b1, 1'b0, 32'h0},
    '{OPC_ALU, SRA, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, OP_A, OP_B,
        {32'h00000000, 32'hC0000000, 32'hFFFFFFFF, 32'h00000000}, 1'b1, 1'b0, 32'h0},
    '{OPC_ALU, SLT, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, OP_A, OP_B,
        {32'h00000000, 32'h00000001, 32'h00000001, 32'h00000000}, 1'b1, 1'b0, 32'h0},
    '{OPC_ALU, SLTU, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, OP_A, OP_B,
        {32'h00000001, 32'h00000000, 32'h00000000, 32'h00000000}, 1'b1, 1'b0, 32'h0},
    '{OPC_MUL, 4'(MULHU), 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 2'd0, MUL_1, MUL_2,
        {32'h00000000, 32'h7FFFFFFE, 32'h40000000, 32'hFFFFFFFE}, 1'b1, 1'b0, 32'h0},
    '{OPC_ALU, LUI, 1'b0, 1'b1, 32'h0, 32'h0, 32'hABCDE000, 2'd0, ZERO, ZERO,
        {4{32'hABCDE000}}, 1'b1, 1'b0, 32'h0},
    '{OPC_ALU, AUIPC, 1'b1, 1'b1, 32'h1000, 32'h1004, 32'h2000, 2'd0, ZERO, ZERO,
        {4{32'h00003000}}, 1'b1, 1'b0, 32'h0},
    '{OPC_BR, BEQ, 1'b1, 1'b1, 32'h100, 32'h104, 32'h40, 2'd2, BR_1, BR_2,
        ZERO, 1'b0, 1'b0, 32'h140},
    '{OPC_BR, BNE, 1'b1, 1'b1, 32'h100, 32'h104, 32'h40, 2'd2, BR_1, BR_2,
        ZERO, 1'b0, 1'b1, 32'h140},
    '{OPC_BR, BLT, 1'b1, 1'b1, 32'h100, 32'h104, 32'h40, 2'd2, BR_1, BR_2,
        ZERO, 1'b0, 1'b1, 32'h140},
    '{OPC_BR, BGE, 1'b1, 1'b1, 32'h100, 32'h104, 32'h40, 2'd2, BR_1, BR_2,
        ZERO, 1'b0, 1'b0, 32'h140},
    '{OPC_BR, BLTU, 1'b1, 1'b1, 32'h100, 32'h104, 32'h40, 2'd2, BR_1, BR_2,
        ZERO, 1'b0, 1'b0, 32'h140},
    '{OPC_BR, BGEU, 1'b1, 1'b1, 32'h100, 32'h104, 32'h40, 2'd2, BR_1, BR_2,
        ZERO, 1'b0, 1'b1, 32'h140},
    '{OPC_BR, JAL, 1'b1, 1'b1, 32'h200, 32'h204, 32'h80, 2'd0, ZERO, ZERO,
        {4{32'h00000204}}, 1'b1, 1'b1, 32'h280},
    '{OPC_BR, JALR, 1'b0, 1'b1, 32'h304, 32'h308, 32'h20, 2'd1, OP_A, ZERO,
        {4{32'h00000308}}, 1'b1, 1'b1, 32'h10}
};

//--- sim/alu_unit_tb.sv
`timescale 1ns/1ps

module alu_unit_tb import simt_alu_pkg::*; ();

    `include "alu_vectors.svh"

    localparam int CYCLE_LIMIT = 20 * NUM_VECS + 100;

    logic        clk = 1'b0;
    logic        reset;
    logic        req_valid;
    logic        req_ready;
    alu_req_t    req;
    logic        commit_valid;
    logic        commit_ready;
    commit_t     commit;
    branch_ctl_t branch_ctl;

    int      cycles = 0;
    int      mismatches = 0;
    int      failures = 0;
    int      done_count = 0;
    int      reset_edges = 0;
    logic    reset_checked = 1'b0;
    logic    done [NUM_VECS] = '{default: 1'b0};
    logic    prev_valid = 1'b0;
    logic    prev_ready = 1'b0;
    commit_t prev_commit;

    alu_unit UUT (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit),
        .branch_ctl   (branch_ctl)
    );

    always #5 clk = ~clk;

    initial begin
        void'($urandom(32'h7e8e8809));
        forever begin
            @(negedge clk);
            commit_ready = ($urandom % 4) != 0;  // About one stall cycle in four
        end
    end

    task automatic report_mismatch(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        mismatches++;
    endtask

    task automatic check_commit();
        int idx;
        idx = int'(commit.rd) - 1;
        if (idx < 0 || idx >= NUM_VECS) begin
            $display("At %0t a commit arrived with unknown rd %0d", $time, commit.rd);
            failures++;
            return;
        end
        if (done[idx]) begin
            $display("At %0t rd %0d was committed a second time", $time, commit.rd);
            failures++;
            return;
        end
        done[idx] = 1'b1;
        done_count++;
        if (commit.wid !== NW_BITS'(idx))
            report_mismatch("commit.wid", XLEN'(commit.wid), XLEN'(NW_BITS'(idx)));
        if (commit.tmask !== NUM_THREADS'(~idx))
            report_mismatch("commit.tmask", XLEN'(commit.tmask), XLEN'(NUM_THREADS'(~idx)));
        if (commit.pc !== vectors[idx].pc)
            report_mismatch("commit.pc", commit.pc, vectors[idx].pc);
        if (commit.wb !== idx[0])
            report_mismatch("commit.wb", XLEN'(commit.wb), XLEN'(idx[0]));
        if (commit.eop !== 1'b1)
            report_mismatch("commit.eop", XLEN'(commit.eop), 32'd1);
        if (vectors[idx].chk_data) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                if (commit.data[t] !== vectors[idx].exp_data[t])
                    report_mismatch($sformatf("commit.data[%0d]", t), commit.data[t],
                                    vectors[idx].exp_data[t]);
            end
        end
        if (vectors[idx].cls == OPC_BR) begin
            if (branch_ctl.valid !== 1'b1) begin
                $display("At %0t branch rd %0d committed without branch_ctl.valid",
                         $time, commit.rd);
                failures++;
            end else begin
                if (branch_ctl.wid !== NW_BITS'(idx))
                    report_mismatch("branch_ctl.wid", XLEN'(branch_ctl.wid),
                                    XLEN'(NW_BITS'(idx)));
                if (branch_ctl.taken !== vectors[idx].taken)
                    report_mismatch("branch_ctl.taken", XLEN'(branch_ctl.taken),
                                    XLEN'(vectors[idx].taken));
                if (branch_ctl.dest !== vectors[idx].dest)
                    report_mismatch("branch_ctl.dest", branch_ctl.dest, vectors[idx].dest);
            end
        end else if (branch_ctl.valid !== 1'b0) begin
            $display("At %0t branch_ctl.valid rose for non-branch rd %0d", $time, commit.rd);
            failures++;
        end
    endtask

    always @(posedge clk) begin
        if (reset_edges > 0 && !reset_checked) begin
            if (commit_valid !== 1'b0 || branch_ctl.valid !== 1'b0) begin
                $display("At %0t a valid output was high during or right after reset", $time);
                failures++;
            end
            if (!reset)
                reset_checked = 1'b1;
        end
        if (reset)
            reset_edges++;
        // Stalled commit must not change
        if (!reset && prev_valid && !prev_ready) begin
            if (commit_valid !== 1'b1) begin
                $display("At %0t commit_valid dropped before the commit was taken", $time);
                failures++;
            end else if (commit !== prev_commit) begin
                $display("mismatch at %0t: commit got %h expected %h", $time, commit,
                         prev_commit);
                mismatches++;
            end
        end
        if (branch_ctl.valid === 1'b1 && !(commit_valid && commit_ready)) begin
            $display("At %0t branch_ctl.valid is high outside a commit transfer", $time);
            failures++;
        end
        if (!reset && commit_valid && commit_ready)
            check_commit();
        prev_valid  = commit_valid;
        prev_ready  = commit_ready;
        prev_commit = commit;
    end

    task automatic report_missing();
        for (int i = 0; i < NUM_VECS; i++) begin
            if (!done[i]) begin
                $display("Row %0d (rd %0d) never committed", i, i + 1);
                failures++;
            end
        end
    endtask

    task automatic print_summary();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d rows committed",
                     cycles, done_count, NUM_VECS);
            failures++;
            report_missing();
            print_summary();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic drive_row(int i);
        req.wid      = NW_BITS'(i);
        req.tmask    = NUM_THREADS'(~i);
        req.pc       = vectors[i].pc;
        req.next_pc  = vectors[i].next_pc;
        req.rd       = NR_BITS'(i + 1);
        req.wb       = i[0];
        req.use_pc   = vectors[i].use_pc;
        req.use_imm  = vectors[i].use_imm;
        req.imm      = vectors[i].imm;
        req.tid      = vectors[i].tid;
        req.op_class = vectors[i].cls;
        req.op_type  = vectors[i].op;
        req.rs1_data = vectors[i].rs1;
        req.rs2_data = vectors[i].rs2;
        req_valid    = 1'b1;
    endtask

    task automatic wait_accept();
        do begin
            @(posedge clk);
        end while (req_ready !== 1'b1);
    endtask

    initial begin
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        commit_ready = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NUM_VECS; i++) begin
            drive_row(i);
            wait_accept();
            @(negedge clk);
        end
        req_valid = 1'b0;
        while (done_count < NUM_VECS)
            @(posedge clk);
        repeat (4) @(posedge clk);  // Catch stray commits
        report_missing();
        print_summary();
        if (mismatches == 0 && failures == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- design/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import simt_alu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    output logic        req_ready,
    input  alu_req_t    req,
    output logic        commit_valid,
    input  logic        commit_ready,
    output commit_t     commit,
    output branch_ctl_t branch_ctl
);

    alu_op_e      alu_op;
    br_op_e       br_op;
    logic         is_br;
    logic         is_mul;
    logic         is_jal;
    logic         is_sub;
    logic         op_signed;
    logic [1:0]   op_class;

    thread_data_t in1_pc;
    thread_data_t in2_imm;
    thread_data_t in2_cmp;
    thread_data_t add_result;
    thread_data_t shr_result;
    thread_data_t msc_result;
    thread_data_t alu_result;
    logic [NUM_THREADS-1:0][XLEN:0] sub_result;
    logic [XLEN:0] cmp_result;

    alu_stage_t   stage_in;
    alu_stage_t   stage_out;
    logic         alu_valid_in;
    logic         alu_ready_in;
    logic         alu_valid_out;
    logic         alu_ready_out;

    mul_side_t    mul_side_in;
    mul_side_t    mul_side_out;
    thread_data_t mul_data;
    commit_t      mul_cmt;
    logic         mul_valid_in;
    logic         mul_ready_in;
    logic         mul_valid_out;
    logic         mul_ready_out;

    assign alu_op    = alu_op_e'(req.op_type);
    assign br_op     = br_op_e'(req.op_type);
    assign is_br     = (req.op_class == OPC_BR);
    assign is_mul    = (req.op_class == OPC_MUL);
    assign is_jal    = is_br && is_jump(br_op);
    assign is_sub    = (alu_op == SUB);
    assign op_signed = alu_op_signed(alu_op);  // Same bit for branch compares
    assign op_class  = alu_op_class(alu_op);

    assign in1_pc  = req.use_pc ? {NUM_THREADS{req.pc}} : req.rs1_data;
    assign in2_imm = req.use_imm ? {NUM_THREADS{req.imm}} : req.rs2_data;
    assign in2_cmp = (req.use_imm && !is_br) ? {NUM_THREADS{req.imm}} : req.rs2_data;

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_thread
        logic [XLEN:0] sub_in1;
        logic [XLEN:0] sub_in2;

        assign sub_in1 = {op_signed & req.rs1_data[i][XLEN-1], req.rs1_data[i]};
        assign sub_in2 = {op_signed & in2_cmp[i][XLEN-1], in2_cmp[i]};

        assign add_result[i] = in1_pc[i] + in2_imm[i];
        assign sub_result[i] = sub_in1 - sub_in2;
        assign shr_result[i] = XLEN'($signed(sub_in1) >>> in2_imm[i][SH_BITS-1:0]);

        always_comb begin
            case (alu_op)
                AND:     msc_result[i] = req.rs1_data[i] & in2_imm[i];
                OR:      msc_result[i] = req.rs1_data[i] | in2_imm[i];
                XOR:     msc_result[i] = req.rs1_data[i] ^ in2_imm[i];
                default: msc_result[i] = req.rs1_data[i] << in2_imm[i][SH_BITS-1:0];
            endcase
        end

        always_comb begin
            case (op_class)
                2'd0:    alu_result[i] = add_result[i];  // ADD, LUI, AUIPC
                2'd1:    alu_result[i] = {{(XLEN-1){1'b0}}, sub_result[i][XLEN]};
                2'd2:    alu_result[i] = is_sub ? sub_result[i][XLEN-1:0] : shr_result[i];
                default: alu_result[i] = msc_result[i];
            endcase
        end
    end

    assign cmp_result = sub_result[req.tid];

    always_comb begin
        stage_in.cmt.wid   = req.wid;
        stage_in.cmt.tmask = req.tmask;
        stage_in.cmt.pc    = req.pc;
        stage_in.cmt.rd    = req.rd;
        stage_in.cmt.wb    = req.wb;
        stage_in.cmt.data  = is_jal ? {NUM_THREADS{req.next_pc}} : alu_result;
        stage_in.cmt.eop   = 1'b1;
        stage_in.is_br     = is_br;
        stage_in.br_op     = br_op;
        stage_in.is_less   = cmp_result[XLEN];
        stage_in.is_equal  = ~(|cmp_result[XLEN-1:0]);
        stage_in.br_dest   = add_result[req.tid];  // pc+imm, or rs1+imm for JALR
    end

    // A stalled multiplier result keeps the commit port until taken
    assign alu_ready_in = commit_ready || (!alu_valid_out && !mul_valid_out);
    assign alu_valid_in = req_valid && !is_mul;

    pipe_register alu_reg (
        .clk       (clk),
        .reset     (reset),
        .enable    (alu_ready_in),
        .valid_in  (alu_valid_in),
        .data_in   (stage_in),
        .valid_out (alu_valid_out),
        .data_out  (stage_out)
    );

    assign alu_ready_out = commit_ready;

    always_comb begin
        branch_ctl.valid = alu_valid_out && alu_ready_out && stage_out.is_br;
        branch_ctl.wid   = stage_out.cmt.wid;
        branch_ctl.taken = ((br_less(stage_out.br_op) ? stage_out.is_less : stage_out.is_equal)
                            ^ br_neg(stage_out.br_op)) | br_static(stage_out.br_op);
        branch_ctl.dest  = stage_out.br_dest;
    end

    always_comb begin
        mul_side_in.wid   = req.wid;
        mul_side_in.tmask = req.tmask;
        mul_side_in.pc    = req.pc;
        mul_side_in.rd    = req.rd;
        mul_side_in.wb    = req.wb;
    end

    assign mul_valid_in  = req_valid && is_mul;
    assign mul_ready_out = commit_ready && !alu_valid_out;  // ALU wins the port

    int_multiplier mul_unit (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (mul_valid_in),
        .ready_in  (mul_ready_in),
        .op        (mul_op_e'(req.op_type[1:0])),
        .side_in   (mul_side_in),
        .in1       (req.rs1_data),
        .in2       (req.rs2_data),
        .valid_out (mul_valid_out),
        .ready_out (mul_ready_out),
        .side_out  (mul_side_out),
        .data_out  (mul_data)
    );

    always_comb begin
        mul_cmt.wid   = mul_side_out.wid;
        mul_cmt.tmask = mul_side_out.tmask;
        mul_cmt.pc    = mul_side_out.pc;
        mul_cmt.rd    = mul_side_out.rd;
        mul_cmt.wb    = mul_side_out.wb;
        mul_cmt.data  = mul_data;
        mul_cmt.eop   = 1'b1;
    end

    assign commit_valid = alu_valid_out || mul_valid_out;
    assign commit       = alu_valid_out ? stage_out.cmt : mul_cmt;

    assign req_ready = is_mul ? mul_ready_in : alu_ready_in;

endmodule

//--- design/int_multiplier.sv
`timescale 1ns/1ps

module int_multiplier import simt_alu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         valid_in,
    output logic         ready_in,
    input  mul_op_e      op,
    input  mul_side_t    side_in,
    input  thread_data_t in1,
    input  thread_data_t in2,
    output logic         valid_out,
    input  logic         ready_out,
    output mul_side_t    side_out,
    output thread_data_t data_out
);

    logic                                 in1_signed;
    logic                                 in2_signed;
    logic [NUM_THREADS-1:0][2*XLEN-1:0]   prod;

    logic                                 valid1;
    mul_op_e                              op1;
    mul_side_t                            side1;
    logic [NUM_THREADS-1:0][2*XLEN-1:0]   prod1;

    logic                                 en1;
    logic                                 en2;

    assign in1_signed = (op == MULH) || (op == MULHSU);
    assign in2_signed = (op == MULH);

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_thread
        logic [XLEN:0]     a;
        logic [XLEN:0]     b;
        logic [2*XLEN+1:0] p;
        assign a = {in1_signed & in1[i][XLEN-1], in1[i]};
        assign b = {in2_signed & in2[i][XLEN-1], in2[i]};
        assign p = $signed(a) * $signed(b);
        assign prod[i] = p[2*XLEN-1:0];  // Low 64 bits hold the full result
    end

    // A stage moves when the one after it is empty or draining
    assign en2      = ~valid_out | ready_out;
    assign en1      = ~valid1 | en2;
    assign ready_in = en1;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid1    <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            if (en1) begin
                valid1 <= valid_in;
            end
            if (en2) begin
                valid_out <= valid1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en1) begin
            op1   <= op;
            side1 <= side_in;
            prod1 <= prod;
        end
        if (en2) begin
            side_out <= side1;
            for (int i = 0; i < NUM_THREADS; i++) begin
                data_out[i] <= (op1 == MUL) ? prod1[i][XLEN-1:0]
                                            : prod1[i][2*XLEN-1:XLEN];
            end
        end
    end

endmodule

//--- design/pipe_register.sv
`timescale 1ns/1ps

module pipe_register import simt_alu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  logic       valid_in,
    input  alu_stage_t data_in,
    output logic       valid_out,
    output alu_stage_t data_out
);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else if (enable) begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            data_out <= data_in;
        end
    end

endmodule

//--- design/simt_alu_pkg.sv
package simt_alu_pkg;

    localparam int NUM_THREADS = 4;
    localparam int NW_BITS     = 2;
    localparam int NR_BITS     = 5;
    localparam int XLEN        = 32;
    localparam int NT_BITS     = $clog2(NUM_THREADS);  // Thread index
    localparam int SH_BITS     = $clog2(XLEN);         // Shift amount

    typedef logic [NUM_THREADS-1:0][XLEN-1:0] thread_data_t;

    typedef enum logic [1:0] {
        OPC_ALU = 2'd0,
        OPC_BR  = 2'd1,
        OPC_MUL = 2'd2
    } op_class_e;

    // Bits [3:2] pick the result class, bit 0 marks a signed op
    typedef enum logic [3:0] {
        ADD   = 4'b0000,
        LUI   = 4'b0010,
        AUIPC = 4'b0011,
        SLTU  = 4'b0100,
        SLT   = 4'b0101,
        SRL   = 4'b1000,
        SRA   = 4'b1001,
        SUB   = 4'b1011,
        AND   = 4'b1100,
        OR    = 4'b1101,
        XOR   = 4'b1110,
        SLL   = 4'b1111
    } alu_op_e;

    typedef enum logic [3:0] {
        BEQ  = 4'b0000,
        BNE  = 4'b0010,
        BLTU = 4'b0100,
        BLT  = 4'b0101,
        BGEU = 4'b0110,
        BGE  = 4'b0111,
        JAL  = 4'b1000,
        JALR = 4'b1001
    } br_op_e;

    typedef enum logic [1:0] {
        MUL    = 2'd0,
        MULH   = 2'd1,
        MULHSU = 2'd2,
        MULHU  = 2'd3
    } mul_op_e;

    function automatic logic [1:0] alu_op_class(alu_op_e op);
        return op[3:2];
    endfunction

    function automatic logic alu_op_signed(alu_op_e op);
        return op[0];
    endfunction

    function automatic logic br_neg(br_op_e op);
        return op[1];
    endfunction

    function automatic logic br_less(br_op_e op);
        return op[2];
    endfunction

    function automatic logic br_static(br_op_e op);
        return op[3];
    endfunction

    function automatic logic is_jump(br_op_e op);
        return op[3];  // JAL and JALR
    endfunction

    typedef struct packed {
        logic [NW_BITS-1:0]     wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [XLEN-1:0]        pc;
        logic [XLEN-1:0]        next_pc;
        logic [NR_BITS-1:0]     rd;
        logic                   wb;
        logic                   use_pc;
        logic                   use_imm;
        logic [XLEN-1:0]        imm;
        logic [NT_BITS-1:0]     tid;
        op_class_e              op_class;
        logic [3:0]             op_type;
        thread_data_t           rs1_data;
        thread_data_t           rs2_data;
    } alu_req_t;

    typedef struct packed {
        logic [NW_BITS-1:0]     wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [XLEN-1:0]        pc;
        logic [NR_BITS-1:0]     rd;
        logic                   wb;
        thread_data_t           data;
        logic                   eop;
    } commit_t;

    typedef struct packed {
        logic               valid;
        logic [NW_BITS-1:0] wid;
        logic               taken;
        logic [XLEN-1:0]    dest;
    } branch_ctl_t;

    typedef struct packed {
        logic [NW_BITS-1:0]     wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [XLEN-1:0]        pc;
        logic [NR_BITS-1:0]     rd;
        logic                   wb;
    } mul_side_t;

    // Contents of the ALU output register
    typedef struct packed {
        commit_t         cmt;
        logic            is_br;
        br_op_e          br_op;
        logic            is_less;
        logic            is_equal;
        logic [XLEN-1:0] br_dest;
    } alu_stage_t;

endpackage
